// File: hdl/ex_alu.sv
////////////////////////////////////////
// Execute ALU
// Operand adder, branch comparator and
// branch target unit, all combinational
////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu (
  ex_alu_if.alu bus
);

  // Step to the next sequential instruction
  ex_pkg::word_t seq_step;
  // Signed views of the operands for BLT and BGE
  logic signed [31:0] op_a_s;
  logic signed [31:0] op_b_s;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // ALU operations only need the sum here, wrap-around is intended
  assign bus.result = bus.op_a + bus.op_b;

  ////////////////////////////////////////
  // Branch comparator
  ////////////////////////////////////////

  assign op_a_s = bus.op_a;
  assign op_b_s = bus.op_b;

  always_comb begin
    case (bus.cmp_op)
      ex_pkg::CMP_BEQ:  bus.cmp_result = (bus.op_a == bus.op_b);
      ex_pkg::CMP_BNE:  bus.cmp_result = (bus.op_a != bus.op_b);
      ex_pkg::CMP_BLT:  bus.cmp_result = (op_a_s < op_b_s);
      ex_pkg::CMP_BGE:  bus.cmp_result = (op_a_s >= op_b_s);
      ex_pkg::CMP_BLTU: bus.cmp_result = (bus.op_a < bus.op_b);
      ex_pkg::CMP_BGEU: bus.cmp_result = (bus.op_a >= bus.op_b);
      // Unused encodings never branch
      default:          bus.cmp_result = 1'b0;
    endcase
  end

  // In data-independent timing mode every branch is taken, so the
  // decision no longer depends on the operand values
  assign bus.branch_decision = bus.cmp_result | bus.dataindtiming;

  ////////////////////////////////////////
  // Branch target
  ////////////////////////////////////////

  // Compressed branches are 2 bytes long, all others 4
  assign seq_step = bus.compressed ? ex_pkg::PC_STEP_C : ex_pkg::PC_STEP_W;

  always_comb begin
    if (bus.cmp_result) begin
      // Real branch, jump by the immediate offset
      bus.branch_target = bus.pc + bus.offset;
    end else begin
      // Untaken compare, which in DIT mode is still a taken branch
      // that lands on the next instruction
      bus.branch_target = bus.pc + seq_step;
    end
  end

endmodule

// File: hdl/ex_alu_if.sv
////////////////////////////////////////
// Execute ALU interface
// Carries the ALU request from the stage
// and the ALU results back, with a
// read-only view for the checker
////////////////////////////////////////

`timescale 1ns/1ps

interface ex_alu_if;

  // Request side, driven from the execute register
  ex_pkg::word_t    op_a;
  ex_pkg::word_t    op_b;
  ex_pkg::word_t    pc;
  ex_pkg::word_t    offset;
  ex_pkg::cmp_op_t  cmp_op;
  logic             compressed;
  logic             dataindtiming;

  // Stage bookkeeping that the checker watches
  ex_pkg::unit_en_t unit_en;
  logic             instr_valid;

  // Result side, all combinational in the ALU
  ex_pkg::word_t    result;
  logic             cmp_result;
  logic             branch_decision;
  ex_pkg::word_t    branch_target;

  modport stage (
    output op_a, op_b, pc, offset, cmp_op, compressed, dataindtiming, unit_en, instr_valid,
    input  result, cmp_result, branch_decision, branch_target
  );

  modport alu (
    input  op_a, op_b, pc, offset, cmp_op, compressed, dataindtiming,
    output result, cmp_result, branch_decision, branch_target
  );

  modport monitor (
    input op_a, op_b, pc, offset, cmp_op, compressed, dataindtiming, unit_en, instr_valid,
    input result, cmp_result, branch_decision, branch_target
  );

endinterface

// File: hdl/ex_pkg.sv
////////////////////////////////////////
// Execute stage package
// Widths, types and encodings shared by
// the execute stage, its ALU and the
// rule checker
////////////////////////////////////////

package ex_pkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // Data and address word, also used for pc, offsets and targets
  typedef logic [31:0] word_t;

  // Branch compare selector, encoded like the funct3 field of the branch opcodes
  typedef enum logic [2:0] {
    CMP_BEQ  = 3'd0,
    CMP_BNE  = 3'd1,
    CMP_BLT  = 3'd4,
    CMP_BGE  = 3'd5,
    CMP_BLTU = 3'd6,
    CMP_BGEU = 3'd7
  } cmp_op_t;

  // One enable per functional unit
  typedef logic [3:0] unit_en_t;

  // Bit positions inside unit_en_t
  localparam int unsigned UNIT_ALU = 0;
  localparam int unsigned UNIT_BCH = 1;
  localparam int unsigned UNIT_CSR = 2;
  localparam int unsigned UNIT_LSU = 3;

  ////////////////////////////////////////
  // Checker flags
  ////////////////////////////////////////

  // Sticky violation flags of the rule checker
  typedef logic [5:0] viol_t;

  // Halt without kill left the stage ready or valid
  localparam int unsigned V_HALT   = 0;
  // Kill left the stage not ready, or still valid
  localparam int unsigned V_KILL   = 1;
  // Illegal CSR access reached writeback with its CSR enable set
  localparam int unsigned V_CSR    = 2;
  // First half of a split access reached writeback with rf_we set
  localparam int unsigned V_SPLIT  = 3;
  // More than one functional unit enabled at once
  localparam int unsigned V_ONEHOT = 4;
  // Data-independent timing broken: branch untaken, bad target or mode change
  localparam int unsigned V_DIT    = 5;

  ////////////////////////////////////////
  // Pc increments
  ////////////////////////////////////////

  // Next-instruction step for compressed instructions
  localparam word_t PC_STEP_C = 32'd2;
  // Next-instruction step for uncompressed instructions
  localparam word_t PC_STEP_W = 32'd4;

endpackage

// File: hdl/ex_stage.sv
////////////////////////////////////////
// Execute stage
// Execute pipeline register with halt and
// kill control, writeback register and
// suppression of CSR and rf write enables
////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n_i,

  // Decode side, sampled when the instruction is accepted
  input  logic              id_valid_i,
  input  ex_pkg::word_t     pc_i,
  input  ex_pkg::word_t     op_a_i,
  input  ex_pkg::word_t     op_b_i,
  input  ex_pkg::word_t     offset_i,
  input  ex_pkg::cmp_op_t   cmp_op_i,
  input  ex_pkg::unit_en_t  unit_en_i,
  input  logic              compressed_i,

  // Levels that apply to the instruction currently in EX
  input  logic              csr_illegal_i,
  input  logic              lsu_split_i,
  input  logic              dataindtiming_i,

  // Controller and writeback handshake
  input  logic              halt_i,
  input  logic              kill_i,
  input  logic              wb_ready_i,

  output logic              ex_ready_o,
  output logic              ex_valid_o,

  // Writeback register
  output logic              wb_valid_o,
  output ex_pkg::word_t     wb_result_o,
  output logic              wb_rf_we_o,
  output logic              wb_csr_en_o,

  // Branch resolution, combinational from the execute register
  output logic              branch_taken_o,
  output ex_pkg::word_t     branch_target_o,

  ex_alu_if.stage           bus
);

  // Execute register contents
  logic              instr_valid_q;
  ex_pkg::word_t     pc_q;
  ex_pkg::word_t     op_a_q;
  ex_pkg::word_t     op_b_q;
  ex_pkg::word_t     offset_q;
  ex_pkg::cmp_op_t   cmp_op_q;
  ex_pkg::unit_en_t  unit_en_q;
  logic              compressed_q;

  // Transfer strobes
  logic              ex_load;
  logic              wb_load;
  // Write enables after suppression
  logic              rf_we_next;
  logic              csr_en_next;

  ////////////////////////////////////////
  // Ready and valid
  ////////////////////////////////////////

  // Kill always frees the stage, halt freezes it otherwise
  assign ex_ready_o = kill_i | (~halt_i & (~instr_valid_q | wb_ready_i));
  assign ex_valid_o = instr_valid_q & ~halt_i & ~kill_i;

  assign ex_load = id_valid_i & ex_ready_o;
  assign wb_load = ex_valid_o & wb_ready_i;

  ////////////////////////////////////////
  // Execute register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      // Either a new instruction arrives or the stage empties
      instr_valid_q <= id_valid_i;
    end
  end

  // Payload only moves on acceptance, its content is qualified by the valid bit
  always_ff @(posedge clk) begin
    if (ex_load) begin
      pc_q         <= pc_i;
      op_a_q       <= op_a_i;
      op_b_q       <= op_b_i;
      offset_q     <= offset_i;
      cmp_op_q     <= cmp_op_i;
      unit_en_q    <= unit_en_i;
      compressed_q <= compressed_i;
    end
  end

  // Present the held instruction to the ALU
  assign bus.op_a          = op_a_q;
  assign bus.op_b          = op_b_q;
  assign bus.pc            = pc_q;
  assign bus.offset        = offset_q;
  assign bus.cmp_op        = cmp_op_q;
  assign bus.compressed    = compressed_q;
  assign bus.dataindtiming = dataindtiming_i;
  assign bus.unit_en       = unit_en_q;
  assign bus.instr_valid   = instr_valid_q;

  ////////////////////////////////////////
  // Writeback register
  ////////////////////////////////////////

  // The first half of a split load/store must not write the register file
  assign rf_we_next = unit_en_q[ex_pkg::UNIT_ALU] | unit_en_q[ex_pkg::UNIT_CSR] |
                      (unit_en_q[ex_pkg::UNIT_LSU] & ~lsu_split_i);
  // Illegal CSR accesses lose their CSR write
  assign csr_en_next = unit_en_q[ex_pkg::UNIT_CSR] & ~csr_illegal_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_csr_en_o <= 1'b0;
    end else if (wb_load) begin
      wb_valid_o  <= 1'b1;
      wb_rf_we_o  <= rf_we_next;
      wb_csr_en_o <= csr_en_next;
    end else if (wb_ready_i) begin
      // Writeback consumed its entry and nothing follows
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_csr_en_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_load) begin
      wb_result_o <= bus.result;
    end
  end

  ////////////////////////////////////////
  // Branch outputs
  ////////////////////////////////////////

  assign branch_taken_o  = ex_valid_o & unit_en_q[ex_pkg::UNIT_BCH] & bus.branch_decision;
  assign branch_target_o = bus.branch_target;

endmodule

// File: hdl/ex_stage_checker.sv
////////////////////////////////////////
// Execute stage checker
// Watches the stage rules at every clock
// edge and keeps one sticky flag for each
// rule that was broken
////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_checker (
  input  logic              clk,
  input  logic              rst_n_i,

  input  logic              halt_i,
  input  logic              kill_i,
  input  logic              ex_ready_i,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  input  ex_pkg::unit_en_t  unit_en_i,
  input  logic              instr_valid_i,
  input  logic              csr_illegal_i,
  input  logic              lsu_split_i,
  input  logic              wb_valid_i,
  input  logic              wb_rf_we_i,
  input  logic              wb_csr_en_i,
  input  logic              branch_taken_i,

  ex_alu_if.monitor         mon,

  output ex_pkg::viol_t     violation_o
);

  // Qualifying conditions captured in the transfer cycle
  logic          csr_chk_q;
  logic          split_chk_q;
  // Previous cycle state for the timing mode rule
  logic          dit_q;
  logic          instr_valid_q;

  logic          transfer;
  ex_pkg::word_t seq_target;
  ex_pkg::viol_t viol_now;

  assign transfer   = ex_valid_i & wb_ready_i;
  assign seq_target = mon.pc + (mon.compressed ? ex_pkg::PC_STEP_C : ex_pkg::PC_STEP_W);

  ////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////

  always_comb begin
    viol_now = '0;
    // Halt without kill must freeze the stage completely
    viol_now[ex_pkg::V_HALT]  = halt_i & ~kill_i & (ex_ready_i | ex_valid_i);
    // Kill must free the stage and drop its instruction
    viol_now[ex_pkg::V_KILL]  = kill_i & (~ex_ready_i | ex_valid_i);
    // Writeback entry from an illegal CSR access still enables the CSR
    viol_now[ex_pkg::V_CSR]   = csr_chk_q & wb_valid_i & wb_csr_en_i;
    // Writeback entry from a first split half still writes the rf
    viol_now[ex_pkg::V_SPLIT] = split_chk_q & wb_valid_i & wb_rf_we_i;
    // Any two enables set at once, x & (x - 1) keeps all but the lowest bit
    viol_now[ex_pkg::V_ONEHOT] = instr_valid_i & ((unit_en_i & (unit_en_i - 1'b1)) != '0);
    // In DIT mode a branch is always taken, an untaken compare lands on the
    // next instruction, and the mode must not move under a valid instruction
    viol_now[ex_pkg::V_DIT] =
      (ex_valid_i & unit_en_i[ex_pkg::UNIT_BCH] & mon.dataindtiming &
       (~branch_taken_i |
        (~mon.cmp_result & (mon.branch_target != seq_target)))) |
      (instr_valid_q & (mon.dataindtiming != dit_q));
  end

  ////////////////////////////////////////
  // History and sticky flags
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      csr_chk_q     <= 1'b0;
      split_chk_q   <= 1'b0;
      dit_q         <= 1'b0;
      instr_valid_q <= 1'b0;
      violation_o   <= '0;
    end else begin
      // Remember which transfers must show suppressed enables next cycle
      csr_chk_q     <= transfer & unit_en_i[ex_pkg::UNIT_CSR] & csr_illegal_i;
      split_chk_q   <= transfer & unit_en_i[ex_pkg::UNIT_LSU] & lsu_split_i;
      dit_q         <= mon.dataindtiming;
      instr_valid_q <= instr_valid_i;
      violation_o   <= violation_o | viol_now;
    end
  end

endmodule

// File: hdl/ex_top.sv
////////////////////////////////////////
// Execute stage top level
// Joins the stage, its ALU and the rule
// checker behind plain ports
////////////////////////////////////////

`timescale 1ns/1ps

module ex_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              id_valid_i,
  input  ex_pkg::word_t     pc_i,
  input  ex_pkg::word_t     op_a_i,
  input  ex_pkg::word_t     op_b_i,
  input  ex_pkg::word_t     offset_i,
  input  ex_pkg::cmp_op_t   cmp_op_i,
  input  ex_pkg::unit_en_t  unit_en_i,
  input  logic              compressed_i,
  input  logic              csr_illegal_i,
  input  logic              lsu_split_i,
  input  logic              dataindtiming_i,
  input  logic              halt_i,
  input  logic              kill_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  output logic              wb_valid_o,
  output ex_pkg::word_t     wb_result_o,
  output logic              wb_rf_we_o,
  output logic              wb_csr_en_o,
  output logic              branch_taken_o,
  output ex_pkg::word_t     branch_target_o,
  output ex_pkg::viol_t     violation_o
);

  // Request and result bus of the ALU
  ex_alu_if alu_bus ();

  ex_stage ex_stage_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .id_valid_i      (id_valid_i),
    .pc_i            (pc_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .offset_i        (offset_i),
    .cmp_op_i        (cmp_op_i),
    .unit_en_i       (unit_en_i),
    .compressed_i    (compressed_i),
    .csr_illegal_i   (csr_illegal_i),
    .lsu_split_i     (lsu_split_i),
    .dataindtiming_i (dataindtiming_i),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .wb_ready_i      (wb_ready_i),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o),
    .wb_valid_o      (wb_valid_o),
    .wb_result_o     (wb_result_o),
    .wb_rf_we_o      (wb_rf_we_o),
    .wb_csr_en_o     (wb_csr_en_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o),
    .bus             (alu_bus)
  );

  ex_alu ex_alu_inst (
    .bus (alu_bus)
  );

  // The checker sees the registered enables and valid through the bus
  ex_stage_checker ex_stage_checker_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .ex_ready_i     (ex_ready_o),
    .ex_valid_i     (ex_valid_o),
    .wb_ready_i     (wb_ready_i),
    .unit_en_i      (alu_bus.unit_en),
    .instr_valid_i  (alu_bus.instr_valid),
    .csr_illegal_i  (csr_illegal_i),
    .lsu_split_i    (lsu_split_i),
    .wb_valid_i     (wb_valid_o),
    .wb_rf_we_i     (wb_rf_we_o),
    .wb_csr_en_i    (wb_csr_en_o),
    .branch_taken_i (branch_taken_o),
    .mon            (alu_bus),
    .violation_o    (violation_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ex_top_tb \
  -f tb.f -o ex_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/ex_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit $status

// File: tb.f
hdl/ex_pkg.sv
hdl/ex_alu_if.sv
hdl/ex_alu.sv
hdl/ex_stage.sv
hdl/ex_stage_checker.sv
hdl/ex_top.sv
testbench/ex_top_tb.sv

// File: testbench/ex_top_tb.sv
////////////////////////////////////////
// Execute stage testbench
// Applies a table of decode and control
// rows to the execute stage top level and
// compares every cycle with a model
////////////////////////////////////////

`timescale 1ns/1ps

module ex_top_tb;

  // One table row is one clock cycle of stimulus plus the outputs expected in it
  typedef struct packed {
    logic             id_valid;
    ex_pkg::word_t    pc;
    ex_pkg::word_t    op_a;
    ex_pkg::word_t    op_b;
    ex_pkg::word_t    offset;
    ex_pkg::cmp_op_t  cmp_op;
    ex_pkg::unit_en_t unit_en;
    logic             compressed;
    logic             csr_illegal;
    logic             lsu_split;
    logic             dit;
    logic             halt;
    logic             kill;
    logic             wb_ready;
    logic             exp_ready;
    logic             exp_valid;
    logic             exp_wb_valid;
    ex_pkg::word_t    exp_result;
    logic             exp_rf_we;
    logic             exp_csr_en;
    logic             exp_taken;
    ex_pkg::word_t    exp_target;
    ex_pkg::viol_t    exp_viol;
  } row_t;

  localparam int MAX_ROWS = 128;

  logic              clk;
  logic              rst_n_i;
  logic              id_valid_i;
  ex_pkg::word_t     pc_i;
  ex_pkg::word_t     op_a_i;
  ex_pkg::word_t     op_b_i;
  ex_pkg::word_t     offset_i;
  ex_pkg::cmp_op_t   cmp_op_i;
  ex_pkg::unit_en_t  unit_en_i;
  logic              compressed_i;
  logic              csr_illegal_i;
  logic              lsu_split_i;
  logic              dataindtiming_i;
  logic              halt_i;
  logic              kill_i;
  logic              wb_ready_i;
  logic              ex_ready_o;
  logic              ex_valid_o;
  logic              wb_valid_o;
  ex_pkg::word_t     wb_result_o;
  logic              wb_rf_we_o;
  logic              wb_csr_en_o;
  logic              branch_taken_o;
  ex_pkg::word_t     branch_target_o;
  ex_pkg::viol_t     violation_o;

  row_t              rows [MAX_ROWS];
  int                n_rows;
  int                cur_row;
  bit                table_built;
  logic [31:0]       lfsr_state;

  // Levels that the row builder copies into every new row
  logic              cfg_dit;
  logic              cfg_illegal;
  logic              cfg_split;

  // Model of the execute register, the writeback register and the checker
  logic              m_hv;
  ex_pkg::word_t     m_pc;
  ex_pkg::word_t     m_a;
  ex_pkg::word_t     m_b;
  ex_pkg::word_t     m_off;
  ex_pkg::cmp_op_t   m_cmp;
  ex_pkg::unit_en_t  m_en;
  logic              m_comp;
  logic              m_wbv;
  ex_pkg::word_t     m_res;
  logic              m_rf;
  logic              m_csr;
  ex_pkg::viol_t     m_viol;
  logic              m_prev_hv;
  logic              m_prev_dit;

  ex_top ex_top_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .id_valid_i      (id_valid_i),
    .pc_i            (pc_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .offset_i        (offset_i),
    .cmp_op_i        (cmp_op_i),
    .unit_en_i       (unit_en_i),
    .compressed_i    (compressed_i),
    .csr_illegal_i   (csr_illegal_i),
    .lsu_split_i     (lsu_split_i),
    .dataindtiming_i (dataindtiming_i),
    .halt_i          (halt_i),
    .kill_i          (kill_i),
    .wb_ready_i      (wb_ready_i),
    .ex_ready_o      (ex_ready_o),
    .ex_valid_o      (ex_valid_o),
    .wb_valid_o      (wb_valid_o),
    .wb_result_o     (wb_result_o),
    .wb_rf_we_o      (wb_rf_we_o),
    .wb_csr_en_o     (wb_csr_en_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o),
    .violation_o     (violation_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random operands and reference model
  ////////////////////////////////////////

  // Right-shifting Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit of the word
  function automatic ex_pkg::word_t rand_word();
    ex_pkg::word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  // The six RISC-V branch compares
  function automatic logic compare_ref(input ex_pkg::cmp_op_t op, input ex_pkg::word_t a,
                                       input ex_pkg::word_t b);
    case (op)
      ex_pkg::CMP_BEQ:  return a == b;
      ex_pkg::CMP_BNE:  return a != b;
      ex_pkg::CMP_BLT:  return $signed(a) < $signed(b);
      ex_pkg::CMP_BGE:  return $signed(a) >= $signed(b);
      ex_pkg::CMP_BLTU: return a < b;
      ex_pkg::CMP_BGEU: return a >= b;
      default:          return 1'b0;
    endcase
  endfunction

  // Fill in the expected outputs of a row, store it, then step the model over the edge
  task automatic push_row(input row_t r);
    row_t          e;
    logic          cmp_true;
    logic          ready;
    logic          valid;
    ex_pkg::viol_t viol_now;
    e = r;
    cmp_true = compare_ref(m_cmp, m_a, m_b);
    ready = r.kill | (~r.halt & (~m_hv | r.wb_ready));
    valid = m_hv & ~r.halt & ~r.kill;
    e.exp_ready    = ready;
    e.exp_valid    = valid;
    e.exp_wb_valid = m_wbv;
    e.exp_result   = m_res;
    e.exp_rf_we    = m_rf;
    e.exp_csr_en   = m_csr;
    e.exp_viol     = m_viol;
    // DIT forces the decision, an untaken compare then lands on the next instruction
    e.exp_taken  = valid & m_en[ex_pkg::UNIT_BCH] & (cmp_true | r.dit);
    e.exp_target = cmp_true ? m_pc + m_off : m_pc + (m_comp ? 32'd2 : 32'd4);
    rows[n_rows] = e;
    n_rows++;
    viol_now = '0;
    viol_now[ex_pkg::V_ONEHOT] = m_hv & ($countones(m_en) > 1);
    viol_now[ex_pkg::V_DIT]    = m_prev_hv & (r.dit != m_prev_dit);
    m_viol     = m_viol | viol_now;
    m_prev_hv  = m_hv;
    m_prev_dit = r.dit;
    if (valid && r.wb_ready) begin
      m_wbv = 1'b1;
      m_res = m_a + m_b;
      m_rf  = m_en[ex_pkg::UNIT_ALU] | m_en[ex_pkg::UNIT_CSR] |
              (m_en[ex_pkg::UNIT_LSU] & ~r.lsu_split);
      m_csr = m_en[ex_pkg::UNIT_CSR] & ~r.csr_illegal;
    end else if (r.wb_ready) begin
      m_wbv = 1'b0;
      m_rf  = 1'b0;
      m_csr = 1'b0;
    end
    if (ready) begin
      if (r.id_valid) begin
        m_pc   = r.pc;
        m_a    = r.op_a;
        m_b    = r.op_b;
        m_off  = r.offset;
        m_cmp  = r.cmp_op;
        m_en   = r.unit_en;
        m_comp = r.compressed;
      end
      m_hv = r.id_valid;
    end
  endtask

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  function automatic row_t make_row(input logic id_valid, input ex_pkg::unit_en_t en,
                                    input ex_pkg::cmp_op_t op, input ex_pkg::word_t pc,
                                    input ex_pkg::word_t a, input ex_pkg::word_t b,
                                    input ex_pkg::word_t off, input logic comp);
    row_t r;
    r = '0;
    r.id_valid    = id_valid;
    r.unit_en     = en;
    r.cmp_op      = op;
    r.pc          = pc;
    r.op_a        = a;
    r.op_b        = b;
    r.offset      = off;
    r.compressed  = comp;
    r.csr_illegal = cfg_illegal;
    r.lsu_split   = cfg_split;
    r.dit         = cfg_dit;
    r.wb_ready    = 1'b1;
    return r;
  endfunction

  task automatic issue(input ex_pkg::unit_en_t en, input ex_pkg::cmp_op_t op,
                       input ex_pkg::word_t pc, input ex_pkg::word_t a,
                       input ex_pkg::word_t b, input ex_pkg::word_t off, input logic comp);
    push_row(make_row(1'b1, en, op, pc, a, b, off, comp));
  endtask

  task automatic idle_rows(input int n);
    for (int i = 0; i < n; i++) begin
      push_row(make_row(1'b0, '0, ex_pkg::CMP_BEQ, '0, '0, '0, '0, 1'b0));
    end
  endtask

  task automatic build_table();
    ex_pkg::cmp_op_t ops [6];
    ex_pkg::word_t   br_a [12];
    ex_pkg::word_t   br_b [12];
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    ex_pkg::word_t   off;
    row_t            r;
    ops  = '{ex_pkg::CMP_BEQ, ex_pkg::CMP_BNE, ex_pkg::CMP_BLT,
             ex_pkg::CMP_BGE, ex_pkg::CMP_BLTU, ex_pkg::CMP_BGEU};
    // Per compare a true pair then a false pair, -3 tests the signed cases
    br_a = '{32'd5, 32'd5, 32'd5, 32'd7, -32'sd3, 32'd2,
             32'd2, -32'sd3, 32'd2, -32'sd3, -32'sd3, 32'd2};
    br_b = '{32'd5, 32'd6, 32'd6, 32'd7, 32'd2, -32'sd3,
             -32'sd3, 32'd2, -32'sd3, 32'd2, 32'd2, -32'sd3};
    n_rows = 0;
    {m_hv, m_wbv, m_rf, m_csr, m_prev_hv, m_prev_dit, m_comp} = '0;
    {m_pc, m_a, m_b, m_off, m_res} = '0;
    m_cmp  = ex_pkg::CMP_BEQ;
    m_en   = '0;
    m_viol = '0;
    {cfg_dit, cfg_illegal, cfg_split} = '0;

    // Three ALU adds back to back
    for (int i = 0; i < 3; i++) begin
      a = rand_word();
      b = rand_word();
      issue(4'b0001, ex_pkg::CMP_BEQ, 32'h100 + 4 * i, a, b, '0, 1'b0);
    end
    idle_rows(3);

    // Branch compares, first normal then with data-independent timing.
    // Two idle rows let the register empty before the mode changes.
    for (int pass = 0; pass < 2; pass++) begin
      cfg_dit = pass[0];
      for (int k = 0; k < 12; k++) begin
        off = k[0] ? 32'hFFFF_FFE0 : 32'h80 + 4 * k;
        issue(4'b0010, ops[k / 2], 32'h2000 + 16 * k, br_a[k], br_b[k], off,
              pass[0] & k[1]);
      end
      idle_rows(2);
    end
    cfg_dit = 1'b0;

    // Halt holds the instruction for two cycles
    issue(4'b0001, ex_pkg::CMP_BEQ, 32'h300, rand_word(), rand_word(), '0, 1'b0);
    r = make_row(1'b0, '0, ex_pkg::CMP_BEQ, '0, '0, '0, '0, 1'b0);
    r.halt = 1'b1;
    push_row(r);
    push_row(r);
    idle_rows(3);

    // Kill drops it in the same cycle
    issue(4'b0001, ex_pkg::CMP_BEQ, 32'h304, rand_word(), rand_word(), '0, 1'b0);
    r.halt = 1'b0;
    r.kill = 1'b1;
    push_row(r);
    idle_rows(2);

    // Writeback not ready, decode keeps offering the next add
    issue(4'b0001, ex_pkg::CMP_BEQ, 32'h308, rand_word(), rand_word(), '0, 1'b0);
    a = rand_word();
    b = rand_word();
    r = make_row(1'b1, 4'b0001, ex_pkg::CMP_BEQ, 32'h30c, a, b, '0, 1'b0);
    r.wb_ready = 1'b0;
    push_row(r);
    push_row(r);
    r.wb_ready = 1'b1;
    push_row(r);
    idle_rows(3);

    // CSR illegal then legal, split first half then second half
    cfg_illegal = 1'b1;
    issue(4'b0100, ex_pkg::CMP_BEQ, 32'h400, rand_word(), rand_word(), '0, 1'b0);
    idle_rows(2);
    cfg_illegal = 1'b0;
    issue(4'b0100, ex_pkg::CMP_BEQ, 32'h404, rand_word(), rand_word(), '0, 1'b0);
    idle_rows(2);
    cfg_split = 1'b1;
    issue(4'b1000, ex_pkg::CMP_BEQ, 32'h408, rand_word(), rand_word(), '0, 1'b0);
    idle_rows(2);
    cfg_split = 1'b0;
    issue(4'b1000, ex_pkg::CMP_BEQ, 32'h40c, rand_word(), rand_word(), '0, 1'b0);
    idle_rows(2);

    // Two units at once, then a mode change under halt
    issue(4'b0011, ex_pkg::CMP_BEQ, 32'h500, 32'd1, 32'd1, 32'h20, 1'b0);
    idle_rows(2);
    issue(4'b0001, ex_pkg::CMP_BEQ, 32'h504, rand_word(), rand_word(), '0, 1'b0);
    r = make_row(1'b0, '0, ex_pkg::CMP_BEQ, '0, '0, '0, '0, 1'b0);
    r.halt = 1'b1;
    push_row(r);
    cfg_dit = 1'b1;
    r.dit = 1'b1;
    push_row(r);
    push_row(r);
    idle_rows(3);
  endtask

  ////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////

  task automatic drive_row(input row_t r);
    id_valid_i      = r.id_valid;
    pc_i            = r.pc;
    op_a_i          = r.op_a;
    op_b_i          = r.op_b;
    offset_i        = r.offset;
    cmp_op_i        = r.cmp_op;
    unit_en_i       = r.unit_en;
    compressed_i    = r.compressed;
    csr_illegal_i   = r.csr_illegal;
    lsu_split_i     = r.lsu_split;
    dataindtiming_i = r.dit;
    halt_i          = r.halt;
    kill_i          = r.kill;
    wb_ready_i      = r.wb_ready;
  endtask

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s = 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input ex_pkg::word_t got,
                            input ex_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %s = 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      abort_run();
    end
  endtask

  task automatic check_viol(input string name, input ex_pkg::viol_t got,
                            input ex_pkg::viol_t exp);
    if (got !== exp) begin
      $display("ERROR %s = 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      abort_run();
    end
  endtask

  task automatic check_row(input row_t r);
    check_bit("ex_ready_o", ex_ready_o, r.exp_ready);
    check_bit("ex_valid_o", ex_valid_o, r.exp_valid);
    check_bit("wb_valid_o", wb_valid_o, r.exp_wb_valid);
    check_bit("wb_rf_we_o", wb_rf_we_o, r.exp_rf_we);
    check_bit("wb_csr_en_o", wb_csr_en_o, r.exp_csr_en);
    check_bit("branch_taken_o", branch_taken_o, r.exp_taken);
    check_viol("violation_o", violation_o, r.exp_viol);
    // Result and target only mean something while their valid is high
    if (r.exp_wb_valid) begin
      check_word("wb_result_o", wb_result_o, r.exp_result);
    end
    if (r.exp_valid) begin
      check_word("branch_target_o", branch_target_o, r.exp_target);
    end
  endtask

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  initial begin
    row_t          quiet;
    ex_pkg::viol_t flags_set;
    quiet = '0;
    quiet.wb_ready = 1'b1;
    drive_row(quiet);
    rst_n_i    = 1'b0;
    cur_row    = -1;
    lfsr_state = 32'hc028;
    build_table();
    table_built = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst_n_i = 1'b1;
    // Drive just after the edge, sample 4 ns later before the next one
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      #1;
      cur_row = i;
      drive_row(rows[i]);
      #4;
      check_row(rows[i]);
    end
    // Both checker flags must still be standing at the end of the table
    flags_set = '0;
    flags_set[ex_pkg::V_ONEHOT] = 1'b1;
    flags_set[ex_pkg::V_DIT]    = 1'b1;
    check_viol("violation_o", violation_o, flags_set);
    // Reset clears the sticky flags and the writeback register
    drive_row(quiet);
    rst_n_i = 1'b0;
    #1;
    check_viol("violation_o", violation_o, '0);
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    check_bit("wb_rf_we_o", wb_rf_we_o, 1'b0);
    check_bit("wb_csr_en_o", wb_csr_en_o, 1'b0);
    $display("All checks passed");
    $finish;
  end

  // Watchdog, sized from the table once it is built
  initial begin
    wait (table_built);
    repeat (20 * n_rows + 100) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", 20 * n_rows + 100);
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
